/* rtl/request_handler.sv */
`timescale 1ns/1ns
`default_nettype none

module request_handler (
	input logic mem_read,
	input logic reset,
	vga_mem_if.server vga,
	input logic [7:0] uart_byte,
	input logic uart_ready,
	input logic [soc_pkg::ADR_W-1:0] cpu_instr_adr,
	input logic [soc_pkg::ADR_W-1:0] cpu_data_adr,
	input logic cpu_read,
	input logic cpu_write,
	input logic [soc_pkg::DATA_W-1:0] cpu_wdata,
	input logic [soc_pkg::SEL_W-1:0] cpu_sel,
	output logic [soc_pkg::DATA_W-1:0] cpu_instr,
	output logic [soc_pkg::DATA_W-1:0] cpu_rdata,
	output logic cpu_enable,
	input logic mem_busy,
	input logic [soc_pkg::DATA_W-1:0] data_from_mem,
	output logic mem_rd,
	output logic mem_write,
	output logic [soc_pkg::ADR_W-1:0] adr_to_mem,
	output logic [soc_pkg::DATA_W-1:0] data_to_mem,
	output logic [soc_pkg::SEL_W-1:0] sel_to_mem
);

	typedef enum logic [2:0] {
		st_idle,
		st_vga,
		st_instr,
		st_data,
		st_respond
	} state_t;

	state_t state;
	logic instr_fetched;
	logic uart_flag;
	logic [7:0] uart_data;
	logic mem_ack;
	logic uart_hit;

	// Access completes on the first edge with the strobe up and busy low.
	assign mem_ack = (mem_rd || mem_write) && !mem_busy;
	assign uart_hit = cpu_data_adr == soc_pkg::ADR_W'(soc_pkg::UART_ADDRESS);

	always_ff @(posedge mem_read) begin
		if (reset) begin
			state <= st_idle;
			mem_rd <= 1'b0;
			mem_write <= 1'b0;
			cpu_enable <= 1'b0;
			vga.done <= 1'b0;
			instr_fetched <= 1'b0;
			uart_flag <= 1'b0;
		end else begin
			vga.done <= 1'b0;

			case (state)
				st_idle: begin
					// VGA wins every access boundary. done still high means that
					// request was just served.
					if (vga.req && !vga.done) begin
						mem_rd <= 1'b1;
						adr_to_mem <= soc_pkg::ADR_W'(soc_pkg::VGA_BASE) + (vga.word_adr << 2);
						sel_to_mem <= '1;
						state <= st_vga;
					end else if (!instr_fetched) begin
						mem_rd <= 1'b1;
						adr_to_mem <= cpu_instr_adr;
						sel_to_mem <= '1;
						state <= st_instr;
					end else if (cpu_read && uart_hit) begin
						cpu_rdata <= {{(soc_pkg::DATA_W - 9){1'b0}}, uart_flag, uart_data};
						uart_flag <= 1'b0;
						cpu_enable <= 1'b1;
						state <= st_respond;
					end else if (cpu_read) begin
						mem_rd <= 1'b1;
						adr_to_mem <= cpu_data_adr;
						sel_to_mem <= cpu_sel;
						state <= st_data;
					end else if (cpu_write && !uart_hit) begin
						mem_write <= 1'b1;
						adr_to_mem <= cpu_data_adr;
						data_to_mem <= cpu_wdata;
						sel_to_mem <= cpu_sel;
						state <= st_data;
					end else begin
						// No data access, or a write to the UART which is dropped.
						cpu_enable <= 1'b1;
						state <= st_respond;
					end
				end

				st_vga: begin
					if (mem_ack) begin
						mem_rd <= 1'b0;
						vga.rdata <= data_from_mem;
						vga.done <= 1'b1;
						state <= st_idle;
					end
				end

				st_instr: begin
					if (mem_ack) begin
						mem_rd <= 1'b0;
						cpu_instr <= data_from_mem;
						instr_fetched <= 1'b1;
						state <= st_idle;
					end
				end

				st_data: begin
					if (mem_ack) begin
						if (mem_rd) begin
							cpu_rdata <= data_from_mem;
						end
						mem_rd <= 1'b0;
						mem_write <= 1'b0;
						cpu_enable <= 1'b1;
						state <= st_respond;
					end
				end

				st_respond: begin
					// cpu_enable is high for this one cycle.
					cpu_enable <= 1'b0;
					instr_fetched <= 1'b0;
					state <= st_idle;
				end

				default: state <= st_idle;
			endcase

			// A new byte wins over a clearing read in the same cycle.
			if (uart_ready) begin
				uart_flag <= 1'b1;
				uart_data <= uart_byte;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/soc_memory_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_memory_subsystem (
	input logic mem_read,
	input logic reset,
	input logic mem_busy,
	input logic [31:0] data_from_mem,
	input logic [31:0] cpu_instr_adr,
	input logic [31:0] cpu_data_adr,
	input logic cpu_read,
	input logic cpu_write,
	input logic [31:0] cpu_wdata,
	input logic [3:0] cpu_sel,
	input logic rx,
	output logic mem_rd,
	output logic mem_write,
	output logic [31:0] adr_to_mem,
	output logic [31:0] data_to_mem,
	output logic [3:0] sel_to_mem,
	output logic [31:0] cpu_instr,
	output logic [31:0] cpu_rdata,
	output logic cpu_enable,
	output logic h_out,
	output logic v_out,
	output logic pixel_data
);

	logic [7:0] uart_byte;
	logic uart_ready;
	logic [9:0] h_count;
	logic [9:0] v_count;

	vga_mem_if vga_bus ();

	request_handler request_handler_i (
		.mem_read (mem_read),
		.reset (reset),
		.vga (vga_bus.server),
		.uart_byte (uart_byte),
		.uart_ready (uart_ready),
		.cpu_instr_adr (cpu_instr_adr),
		.cpu_data_adr (cpu_data_adr),
		.cpu_read (cpu_read),
		.cpu_write (cpu_write),
		.cpu_wdata (cpu_wdata),
		.cpu_sel (cpu_sel),
		.cpu_instr (cpu_instr),
		.cpu_rdata (cpu_rdata),
		.cpu_enable (cpu_enable),
		.mem_busy (mem_busy),
		.data_from_mem (data_from_mem),
		.mem_rd (mem_rd),
		.mem_write (mem_write),
		.adr_to_mem (adr_to_mem),
		.data_to_mem (data_to_mem),
		.sel_to_mem (sel_to_mem)
	);

	uart_receiver uart_receiver_i (
		.mem_read (mem_read),
		.reset (reset),
		.rx (rx),
		.data_out (uart_byte),
		.data_ready (uart_ready)
	);

	vga_timing vga_timing_i (
		.mem_read (mem_read),
		.reset (reset),
		.h_count (h_count),
		.v_count (v_count),
		.h_out (h_out),
		.v_out (v_out)
	);

	vga_fetch vga_fetch_i (
		.mem_read (mem_read),
		.reset (reset),
		.h_count (h_count),
		.v_count (v_count),
		.mem (vga_bus.requester),
		.pixel_data (pixel_data)
	);

endmodule

`default_nettype wire

/* rtl/soc_pkg.sv */
`default_nettype none

package soc_pkg;

	// ******************************
	// Bus widths
	// ******************************
	localparam int DATA_W = 32;
	localparam int ADR_W = 32;
	localparam int SEL_W = 4;

	// ******************************
	// Address map
	// ******************************
	// UART status word, byte address.
	localparam int UART_ADDRESS = 1000;
	// Frame buffer word 0, byte address.
	localparam int VGA_BASE = 2000;
	// 640 pixels at one bit each.
	localparam int WORDS_PER_LINE = 20;

	// ******************************
	// VGA timing, 640x480
	// ******************************
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT = 16;
	localparam int H_SYNC = 96;
	localparam int H_BACK = 48;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	localparam int V_ACTIVE = 480;
	localparam int V_FRONT = 10;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 33;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// First word of a line is requested this many clocks before column 0.
	localparam int FETCH_LEAD = 32;

	// ******************************
	// UART
	// ******************************
	localparam int CLKS_PER_BIT = 16;

endpackage

`default_nettype wire

/* rtl/uart_receiver.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_receiver (
	input logic mem_read,
	input logic reset,
	input logic rx,
	output logic [7:0] data_out,
	output logic data_ready
);

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} state_t;

	state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic [$clog2(soc_pkg::CLKS_PER_BIT)-1:0] baud_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift_reg;
	logic half_bit;
	logic full_bit;

	assign half_bit = baud_cnt == ($bits(baud_cnt))'(soc_pkg::CLKS_PER_BIT / 2 - 1);
	assign full_bit = baud_cnt == ($bits(baud_cnt))'(soc_pkg::CLKS_PER_BIT - 1);

	// Two flop synchroniser, idle line is high.
	always_ff @(posedge mem_read) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge mem_read) begin
		if (reset) begin
			state <= st_idle;
			baud_cnt <= '0;
			bit_idx <= '0;
			data_ready <= 1'b0;
		end else begin
			data_ready <= 1'b0;
			baud_cnt <= baud_cnt + 1'b1;

			case (state)
				st_idle: begin
					baud_cnt <= '0;
					if (rx_prev && !rx_sync) begin
						state <= st_start;
					end
				end

				// Wait to the middle of the start bit, then recheck it.
				st_start: begin
					if (half_bit) begin
						baud_cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? st_idle : st_data;
					end
				end

				st_data: begin
					if (full_bit) begin
						baud_cnt <= '0;
						shift_reg <= {rx_sync, shift_reg[7:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= st_stop;
						end
					end
				end

				st_stop: begin
					if (full_bit) begin
						// Framing error drops the byte.
						if (rx_sync) begin
							data_out <= shift_reg;
							data_ready <= 1'b1;
						end
						state <= st_idle;
					end
				end

				default: state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/vga_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module vga_fetch (
	input logic mem_read,
	input logic reset,
	input logic [9:0] h_count,
	input logic [9:0] v_count,
	vga_mem_if.requester mem,
	output logic pixel_data
);

	logic [9:0] nx_h;
	logic [9:0] nx_v;
	logic [9:0] lead_line;
	logic nx_active;
	logic lead_start;
	logic next_req;
	logic [soc_pkg::DATA_W-1:0] word_buf;
	logic [soc_pkg::DATA_W-1:0] shift_reg;

	// Position shown in the next cycle.
	always_comb begin
		nx_h = h_count + 10'd1;
		nx_v = v_count;
		if (h_count == 10'(soc_pkg::H_TOTAL - 1)) begin
			nx_h = '0;
			nx_v = (v_count == 10'(soc_pkg::V_TOTAL - 1)) ? '0 : v_count + 10'd1;
		end
	end

	assign nx_active = nx_h < 10'(soc_pkg::H_ACTIVE) && nx_v < 10'(soc_pkg::V_ACTIVE);
	assign lead_line = (v_count == 10'(soc_pkg::V_TOTAL - 1)) ? '0 : v_count + 10'd1;

	// First word of the coming line, FETCH_LEAD clocks ahead of column 0.
	assign lead_start = h_count == 10'(soc_pkg::H_TOTAL - soc_pkg::FETCH_LEAD - 1) &&
		lead_line < 10'(soc_pkg::V_ACTIVE);

	// At a word boundary, ask for the word after the one being loaded.
	assign next_req = nx_active && nx_h[4:0] == 5'd0 &&
		nx_h[9:5] < 5'(soc_pkg::WORDS_PER_LINE - 1);

	always_ff @(posedge mem_read) begin
		if (reset) begin
			mem.req <= 1'b0;
			mem.word_adr <= '0;
			shift_reg <= '0;
		end else begin
			if (lead_start) begin
				mem.req <= 1'b1;
				mem.word_adr <= soc_pkg::ADR_W'(lead_line) *
					soc_pkg::ADR_W'(soc_pkg::WORDS_PER_LINE);
			end else if (next_req) begin
				mem.req <= 1'b1;
				mem.word_adr <= soc_pkg::ADR_W'(nx_v) *
					soc_pkg::ADR_W'(soc_pkg::WORDS_PER_LINE) +
					soc_pkg::ADR_W'(nx_h[9:5]) + 1'b1;
			end else if (mem.done) begin
				mem.req <= 1'b0;
			end

			if (nx_active) begin
				if (nx_h[4:0] == 5'd0) begin
					shift_reg <= word_buf;
				end else begin
					shift_reg <= shift_reg << 1;
				end
			end
		end
	end

	always_ff @(posedge mem_read) begin
		if (mem.done) begin
			word_buf <= mem.rdata;
		end
	end

	// MSB first, blank outside the active area.
	assign pixel_data = (h_count < 10'(soc_pkg::H_ACTIVE) && v_count < 10'(soc_pkg::V_ACTIVE)) ?
		shift_reg[soc_pkg::DATA_W-1] : 1'b0;

endmodule

`default_nettype wire

/* rtl/vga_mem_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Frame fetcher to request handler link.
// req and word_adr hold until done, rdata is valid on the done cycle.
interface vga_mem_if;

	logic req;
	logic [soc_pkg::ADR_W-1:0] word_adr;
	logic [soc_pkg::DATA_W-1:0] rdata;
	logic done;

	modport requester (
		output req,
		output word_adr,
		input rdata,
		input done
	);

	modport server (
		input req,
		input word_adr,
		output rdata,
		output done
	);

endinterface

`default_nettype wire

/* rtl/vga_timing.sv */
`timescale 1ns/1ns
`default_nettype none

module vga_timing (
	input logic mem_read,
	input logic reset,
	output logic [9:0] h_count,
	output logic [9:0] v_count,
	output logic h_out,
	output logic v_out
);

	localparam int H_SYNC_START = soc_pkg::H_ACTIVE + soc_pkg::H_FRONT;
	localparam int H_SYNC_END = H_SYNC_START + soc_pkg::H_SYNC;
	localparam int V_SYNC_START = soc_pkg::V_ACTIVE + soc_pkg::V_FRONT;
	localparam int V_SYNC_END = V_SYNC_START + soc_pkg::V_SYNC;

	logic [9:0] h_next;
	logic [9:0] v_next;
	logic line_end;

	assign line_end = h_count == 10'(soc_pkg::H_TOTAL - 1);

	// ******************************
	// Next counter values
	// ******************************
	always_comb begin
		h_next = h_count + 10'd1;
		v_next = v_count;
		if (line_end) begin
			h_next = '0;
			if (v_count == 10'(soc_pkg::V_TOTAL - 1)) begin
				v_next = '0;
			end else begin
				v_next = v_count + 10'd1;
			end
		end
	end

	// Sync is decoded from the next count, so it lines up with the counters.
	always_ff @(posedge mem_read) begin
		if (reset) begin
			h_count <= '0;
			v_count <= '0;
			h_out <= 1'b1;
			v_out <= 1'b1;
		end else begin
			h_count <= h_next;
			v_count <= v_next;
			h_out <= !(h_next >= 10'(H_SYNC_START) && h_next < 10'(H_SYNC_END));
			v_out <= !(v_next >= 10'(V_SYNC_START) && v_next < 10'(V_SYNC_END));
		end
	end

endmodule

`default_nettype wire

/* verification/tb_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model (
	input logic clk,
	input logic mem_rd,
	input logic mem_write,
	input logic [31:0] adr,
	input logic [31:0] wdata,
	input logic [3:0] sel,
	output logic mem_busy,
	output logic [31:0] rdata
);

	logic [31:0] store [logic [31:0]];
	logic [31:0] log_adr [$];
	logic [31:0] log_data [$];
	logic [3:0] log_sel [$];
	bit in_access;
	int unsigned busy_left;

	// Unwritten words read as the inverted address plus the address rotated left by 7.
	function automatic logic [31:0] word_at(input logic [31:0] a);
		if (store.exists(a)) begin
			return store[a];
		end
		return ~a + {a[24:0], a[31:25]};
	endfunction

	task automatic preload(input logic [31:0] a, input logic [31:0] d);
		store[a] = d;
	endtask

	initial begin
		mem_busy = 1'b0;
		rdata = '0;
		in_access = 1'b0;
		busy_left = 0;
	end

	// Busy is picked once per access, 0 to 11 cycles.
	always @(negedge clk) begin
		if (mem_rd || mem_write) begin
			if (!in_access) begin
				in_access = 1'b1;
				busy_left = $urandom % 12;
			end
			mem_busy <= busy_left != 0;
			if (busy_left != 0) begin
				busy_left = busy_left - 1;
			end
			rdata <= word_at(adr);
		end else begin
			in_access = 1'b0;
			mem_busy <= 1'b0;
		end
	end

	always @(posedge clk) begin
		logic [31:0] w;
		if (mem_write && !mem_busy) begin
			w = word_at(adr);
			for (int i = 0; i < 4; i++) begin
				if (sel[i]) begin
					w[8*i +: 8] = wdata[8*i +: 8];
				end
			end
			store[adr] = w;
			log_adr.push_back(adr);
			log_data.push_back(wdata);
			log_sel.push_back(sel);
		end
	end

endmodule

`default_nettype wire

/* verification/tb_soc_memory_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_soc_memory_subsystem;

	localparam int FRAME_WORDS = soc_pkg::WORDS_PER_LINE * soc_pkg::V_ACTIVE;

	logic clk;
	logic reset;
	logic mem_busy;
	logic [31:0] data_from_mem;
	logic [31:0] cpu_instr_adr;
	logic [31:0] cpu_data_adr;
	logic cpu_read;
	logic cpu_write;
	logic [31:0] cpu_wdata;
	logic [3:0] cpu_sel;
	logic rx;
	logic mem_rd;
	logic mem_write;
	logic [31:0] adr_to_mem;
	logic [31:0] data_to_mem;
	logic [3:0] sel_to_mem;
	logic [31:0] cpu_instr;
	logic [31:0] cpu_rdata;
	logic cpu_enable;
	logic h_out;
	logic v_out;
	logic pixel_data;

	logic [31:0] frame_words [0:FRAME_WORDS-1];
	logic [31:0] shadow [logic [31:0]];
	logic [31:0] got_instr;
	logic [31:0] got_data;
	bit frame_done;
	bit synced;
	int th;
	int tv;
	int lines;
	logic last_v;
	logic last_strobe;
	logic last_rd;
	logic last_wr;
	logic [31:0] last_adr;

	always #4 clk = ~clk;

	soc_memory_subsystem soc_memory_subsystem_i (
		.mem_read (clk),
		.reset (reset),
		.mem_busy (mem_busy),
		.data_from_mem (data_from_mem),
		.cpu_instr_adr (cpu_instr_adr),
		.cpu_data_adr (cpu_data_adr),
		.cpu_read (cpu_read),
		.cpu_write (cpu_write),
		.cpu_wdata (cpu_wdata),
		.cpu_sel (cpu_sel),
		.rx (rx),
		.mem_rd (mem_rd),
		.mem_write (mem_write),
		.adr_to_mem (adr_to_mem),
		.data_to_mem (data_to_mem),
		.sel_to_mem (sel_to_mem),
		.cpu_instr (cpu_instr),
		.cpu_rdata (cpu_rdata),
		.cpu_enable (cpu_enable),
		.h_out (h_out),
		.v_out (v_out),
		.pixel_data (pixel_data)
	);

	tb_mem_model mem_model_i (
		.clk (clk),
		.mem_rd (mem_rd),
		.mem_write (mem_write),
		.adr (adr_to_mem),
		.wdata (data_to_mem),
		.sel (sel_to_mem),
		.mem_busy (mem_busy),
		.rdata (data_from_mem)
	);

	// ******************************
	// Reporting and expected values
	// ******************************
	task automatic stop_on_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("FAIL %s expected %h actual %h", name, exp, act);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else stop_on_value(name, exp, act);
	endtask

	function automatic logic [31:0] expected_word(input logic [31:0] a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return ~a + {a[24:0], a[31:25]};
	endfunction

	function automatic logic [31:0] random_adr();
		return 32'h0001_0000 + ($urandom % 16384) * 4;
	endfunction

	// ******************************
	// CPU bus
	// ******************************
	task automatic wait_enable();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			assert (n < 300) else stop_on_error("cpu_enable did not pulse within 300 cycles");
		end while (!cpu_enable);
	endtask

	// New request goes out on a cpu_enable cycle, then the next pulse answers it.
	task automatic cpu_access(input logic [31:0] iadr, input logic [31:0] dadr, input logic rd,
		input logic wr, input logic [31:0] wdata, input logic [3:0] sel);
		wait_enable();
		cpu_instr_adr = iadr;
		cpu_data_adr = dadr;
		cpu_read = rd;
		cpu_write = wr;
		cpu_wdata = wdata;
		cpu_sel = sel;
		wait_enable();
		got_instr = cpu_instr;
		got_data = cpu_rdata;
		cpu_read = 1'b0;
		cpu_write = 1'b0;
	endtask

	task automatic read_check(input logic [31:0] iadr, input logic [31:0] dadr);
		cpu_access(iadr, dadr, 1'b1, 1'b0, '0, 4'hf);
		check_value("cpu_read instr", expected_word(iadr), got_instr);
		check_value("cpu_read data", expected_word(dadr), got_data);
	endtask

	task automatic write_check(input logic [31:0] dadr, input logic [31:0] wdata,
		input logic [3:0] sel);
		logic [31:0] w;
		cpu_access(random_adr(), dadr, 1'b0, 1'b1, wdata, sel);
		assert (mem_model_i.log_adr.size() == 1) else stop_on_error("write was not logged once");
		check_value("write adr", dadr, mem_model_i.log_adr.pop_front());
		check_value("write data", wdata, mem_model_i.log_data.pop_front());
		check_value("write sel", 32'(sel), 32'(mem_model_i.log_sel.pop_front()));
		w = expected_word(dadr);
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				w[8*i +: 8] = wdata[8*i +: 8];
			end
		end
		shadow[dadr] = w;
	endtask

	// 8N1 frame sent LSB first.
	task automatic send_byte(input logic [7:0] b, input logic stop);
		logic [9:0] bits;
		bits = {stop, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rx = bits[i];
			repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk);
		end
		rx = 1'b1;
		repeat (3 * soc_pkg::CLKS_PER_BIT) @(negedge clk);
	endtask

	// ******************************
	// Video and memory port monitor
	// ******************************
	always @(negedge clk) begin
		if (!reset) begin
			assert (!(mem_rd && mem_write)) else stop_on_error("mem_rd and mem_write both high");
			// Busy seen here is the value at the last rising edge.
			if (last_strobe && mem_busy) begin
				check_value("strobe mem_rd", 32'(last_rd), 32'(mem_rd));
				check_value("strobe mem_write", 32'(last_wr), 32'(mem_write));
				check_value("strobe adr", last_adr, adr_to_mem);
			end
			if (synced) begin
				th++;
				if (th == soc_pkg::H_TOTAL) begin
					th = 0;
					tv = (tv == soc_pkg::V_TOTAL - 1) ? 0 : tv + 1;
					lines++;
				end
			end else if (last_v && !v_out) begin
				synced = 1'b1;
				th = 0;
				tv = 490;
			end
			if (synced && !frame_done) begin
				check_value("h_out", 32'(!(th >= 656 && th < 752)), 32'(h_out));
				check_value("v_out", 32'(!(tv >= 490 && tv < 492)), 32'(v_out));
				if (th < soc_pkg::H_ACTIVE && tv < soc_pkg::V_ACTIVE) begin
					check_value("pixel_data",
						32'(frame_words[tv * soc_pkg::WORDS_PER_LINE + th / 32][31 - th % 32]),
						32'(pixel_data));
				end
				if (lines == soc_pkg::V_TOTAL) begin
					frame_done = 1'b1;
				end
			end
		end
		last_v = v_out;
		last_strobe = mem_rd || mem_write;
		last_rd = mem_rd;
		last_wr = mem_write;
		last_adr = adr_to_mem;
	end

	// ******************************
	// Main sequence
	// ******************************
	initial begin
		logic [7:0] b;
		void'($urandom(32'ha225));
		clk = 1'b0;
		reset = 1'b1;
		cpu_instr_adr = '0;
		cpu_data_adr = '0;
		cpu_read = 1'b0;
		cpu_write = 1'b0;
		cpu_wdata = '0;
		cpu_sel = '0;
		rx = 1'b1;
		frame_done = 1'b0;
		synced = 1'b0;
		lines = 0;
		last_v = 1'b1;
		last_strobe = 1'b0;
		for (int i = 0; i < FRAME_WORDS; i++) begin
			frame_words[i] = $urandom;
			mem_model_i.preload(soc_pkg::VGA_BASE + 4 * i, frame_words[i]);
		end

		repeat (10) begin
			@(negedge clk);
			check_value("reset mem_rd", 0, 32'(mem_rd));
			check_value("reset mem_write", 0, 32'(mem_write));
			check_value("reset cpu_enable", 0, 32'(cpu_enable));
			check_value("reset h_out", 1, 32'(h_out));
			check_value("reset v_out", 1, 32'(v_out));
			check_value("reset pixel_data", 0, 32'(pixel_data));
		end
		reset = 1'b0;

		for (int i = 0; i < 20; i++) begin
			read_check(random_adr(), random_adr());
		end
		for (int i = 0; i < 10; i++) begin
			write_check(32'h0002_0000 + 4 * i, $urandom, 4'($urandom));
			read_check(random_adr(), 32'h0002_0000 + 4 * i);
		end

		b = 8'($urandom);
		send_byte(b, 1'b1);
		cpu_access(random_adr(), soc_pkg::UART_ADDRESS, 1'b1, 1'b0, '0, 4'hf);
		check_value("uart first read", {23'd0, 1'b1, b}, got_data);
		cpu_access(random_adr(), soc_pkg::UART_ADDRESS, 1'b1, 1'b0, '0, 4'hf);
		check_value("uart second read flag", 0, 32'(got_data[8]));
		send_byte(8'($urandom), 1'b0);
		cpu_access(random_adr(), soc_pkg::UART_ADDRESS, 1'b1, 1'b0, '0, 4'hf);
		check_value("uart bad stop flag", 0, 32'(got_data[8]));

		// Random CPU traffic while the monitor checks one full frame.
		while (!frame_done) begin
			assert ($time < 64'd8_000_000) else stop_on_error("frame check did not complete");
			if ($urandom % 3 == 0) begin
				write_check(random_adr(), $urandom, 4'($urandom));
			end else begin
				read_check(random_adr(), random_adr());
			end
		end

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
rtl/soc_pkg.sv
rtl/vga_mem_if.sv
rtl/request_handler.sv
rtl/uart_receiver.sv
rtl/vga_timing.sv
rtl/vga_fetch.sv
rtl/soc_memory_subsystem.sv
verification/tb_mem_model.sv
verification/tb_soc_memory_subsystem.sv
